// File: Bender.yml
package:
  name: nes_board

sources:
  - files:
      - hw/nes_board_pkg.sv
      - hw/rv_mem_bridge.sv
      - hw/rom_load_ctrl.sv
      - hw/joypad_port.sv
      - hw/nes_board_top.sv
  - target: test
    files:
      - test/nes_board_chk.sv
      - test/nes_board_tb.sv

// File: build.f
hw/nes_board_pkg.sv
hw/rv_mem_bridge.sv
hw/rom_load_ctrl.sv
hw/joypad_port.sv
hw/nes_board_top.sv
test/nes_board_chk.sv
test/nes_board_tb.sv

// File: hw/joypad_port.sv
//////////////////////////////
// one NES controller port
// loads the buttons on strobe with autofire on A and B,
// shifts them out on falling edges of the joypad clock
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module joypad_port (
    input  wire                             clk,
    input  wire                             sys_resetn,
    input  wire [nes_board_pkg::BTN_W-1:0]  i_buttons,
    input  wire                             i_strobe,
    input  wire                             i_joy_clk,
    output logic                            o_joy_data
);

    logic [$clog2(nes_board_pkg::AUTOFIRE_HALF_PERIOD)-1:0] af_cnt [2];
    logic [1:0]                            af_fire;     // bit 0 fires A, bit 1 fires B
    logic [1:0]                            joy_clk_r;
    logic [nes_board_pkg::NES_BTN_W-1:0]   bits;

    wire [1:0] af_req   = {i_buttons[nes_board_pkg::AUTO_B_BTN],
                           i_buttons[nes_board_pkg::AUTO_A_BTN]};
    wire       clk_fall = joy_clk_r[1] & ~joy_clk_r[0];

    //////////////////////////////
    // autofire
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            af_fire <= 2'b00;
            for (int i = 0; i < 2; i++)
                af_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!af_req[i]) begin
                    af_cnt[i]  <= '0;       // released, restart low
                    af_fire[i] <= 1'b0;
                end else if (af_cnt[i] == nes_board_pkg::AUTOFIRE_HALF_PERIOD - 1) begin
                    af_cnt[i]  <= '0;
                    af_fire[i] <= ~af_fire[i];
                end else begin
                    af_cnt[i] <= af_cnt[i] + 1'b1;
                end
            end
        end
    end

    // joypad clock edge detect
    always_ff @(posedge clk) begin
        if (!sys_resetn)
            joy_clk_r <= 2'b00;
        else
            joy_clk_r <= {joy_clk_r[0], i_joy_clk};
    end

    //////////////////////////////
    // serial shift out
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_strobe)
            bits <= {i_buttons[nes_board_pkg::NES_BTN_W-1:2],
                     i_buttons[1] | af_fire[1],
                     i_buttons[0] | af_fire[0]};
        else if (clk_fall)
            bits <= {1'b1, bits[nes_board_pkg::NES_BTN_W-1:1]};  // ones after last button
    end

    assign o_joy_data = bits[0];

endmodule

`default_nettype wire

// File: hw/nes_board_pkg.sv
//////////////////////////////
// shared widths, button indices, mapper numbers and
// bridge states for the board glue logic
// referenced by scoped name from each RTL file
//////////////////////////////

`default_nettype none

package nes_board_pkg;

    //////////////////////////////
    // address and data widths
    //////////////////////////////
    localparam int NES_ADDR_W  = 22;    // NES cpu and loader byte address
    localparam int RV_ADDR_W   = 23;    // softcore byte address
    localparam int HALF_ADDR_W = 20;    // word addr [20:2] plus half select

    //////////////////////////////
    // controller
    //////////////////////////////
    // SNES layout, lower 8 bits are the NES buttons
    localparam int BTN_W      = 12;
    localparam int NES_BTN_W  = 8;
    localparam int AUTO_A_BTN = 8;      // autofire request on A
    localparam int AUTO_B_BTN = 9;      // autofire request on B

    // clk cycles per autofire level
    localparam int AUTOFIRE_HALF_PERIOD = 8;

    //////////////////////////////
    // mapper flags
    //////////////////////////////
    localparam int MAPPER_W = 8;
    localparam int FLAGS_W  = 64;

    // mappers with expansion audio, entry 0 in the low byte
    localparam int EXT_AUDIO_N = 3;
    localparam logic [EXT_AUDIO_N*MAPPER_W-1:0] EXT_AUDIO_MAPPERS = {8'd26, 8'd24, 8'd19};

    // softcore bridge FSM
    typedef enum logic [2:0] {
        RV_IDLE,        // waiting for an access
        RV_WAIT0,       // low half outstanding
        RV_DATA0,       // capture low half
        RV_WAIT1,       // high half outstanding
        RV_DATA1        // return read data
    } rv_state_e;

endpackage

`default_nettype wire

// File: hw/nes_board_top.sv
//////////////////////////////
// board glue between NES core, SDRAM, softcore and pads
// softcore bridge, ROM load control and two joypad ports
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module nes_board_top (
    input  wire                                  clk,
    input  wire                                  sys_resetn,
    // softcore
    input  wire                                  i_rv_valid,
    input  wire [nes_board_pkg::RV_ADDR_W-1:0]   i_rv_addr,
    input  wire [31:0]                           i_rv_wdata,
    input  wire [3:0]                            i_rv_wstrb,
    output wire                                  o_rv_ready,
    output wire [31:0]                           o_rv_rdata,
    // memory softcore port
    output wire                                  o_mem_req,
    input  wire                                  i_mem_req_ack,
    output wire [nes_board_pkg::HALF_ADDR_W-1:0] o_mem_addr,
    output wire [15:0]                           o_mem_din,
    output wire [1:0]                            o_mem_ds,
    output wire                                  o_mem_we,
    input  wire [15:0]                           i_mem_dout,
    // loader
    input  wire                                  i_loading,
    input  wire                                  i_loader_write,
    input  wire [nes_board_pkg::NES_ADDR_W-1:0]  i_loader_addr,
    input  wire [7:0]                            i_loader_data,
    input  wire                                  i_loader_done,
    input  wire [nes_board_pkg::FLAGS_W-1:0]     i_loader_flags,
    // NES cpu and memory cpu port
    input  wire [nes_board_pkg::NES_ADDR_W-1:0]  i_cpu_addr,
    input  wire [7:0]                            i_cpu_dout,
    input  wire                                  i_cpu_write,
    input  wire                                  i_cpu_read,
    output wire [nes_board_pkg::NES_ADDR_W-1:0]  o_cpu_mem_addr,
    output wire [7:0]                            o_cpu_mem_din,
    output wire                                  o_cpu_mem_we,
    output wire                                  o_cpu_mem_oe,
    // console control
    output wire                                  o_reset_nes,
    output wire                                  o_clkref,
    output wire [nes_board_pkg::FLAGS_W-1:0]     o_mapper_flags,
    output wire                                  o_ext_audio,
    // joypads
    input  wire [nes_board_pkg::BTN_W-1:0]       i_joy1_btns,
    input  wire [nes_board_pkg::BTN_W-1:0]       i_joy2_btns,
    input  wire                                  i_joypad_strobe,
    input  wire [1:0]                            i_joypad_clock,
    output wire                                  o_joypad1_data,
    output wire                                  o_joypad2_data
);

    rv_mem_bridge u_bridge (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata),
        .o_mem_req(o_mem_req), .i_mem_req_ack(i_mem_req_ack),
        .o_mem_addr(o_mem_addr), .o_mem_din(o_mem_din),
        .o_mem_ds(o_mem_ds), .o_mem_we(o_mem_we),
        .i_mem_dout(i_mem_dout)
    );

    rom_load_ctrl u_load (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_loading(i_loading), .i_loader_write(i_loader_write),
        .i_loader_addr(i_loader_addr), .i_loader_data(i_loader_data),
        .i_loader_done(i_loader_done), .i_loader_flags(i_loader_flags),
        .i_cpu_addr(i_cpu_addr), .i_cpu_dout(i_cpu_dout),
        .i_cpu_write(i_cpu_write), .i_cpu_read(i_cpu_read),
        .o_cpu_mem_addr(o_cpu_mem_addr), .o_cpu_mem_din(o_cpu_mem_din),
        .o_cpu_mem_we(o_cpu_mem_we), .o_cpu_mem_oe(o_cpu_mem_oe),
        .o_reset_nes(o_reset_nes), .o_clkref(o_clkref),
        .o_mapper_flags(o_mapper_flags), .o_ext_audio(o_ext_audio)
    );

    // one port per controller, shared strobe
    joypad_port u_joy1 (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_buttons(i_joy1_btns), .i_strobe(i_joypad_strobe),
        .i_joy_clk(i_joypad_clock[0]), .o_joy_data(o_joypad1_data)
    );

    joypad_port u_joy2 (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_buttons(i_joy2_btns), .i_strobe(i_joypad_strobe),
        .i_joy_clk(i_joypad_clock[1]), .o_joy_data(o_joypad2_data)
    );

endmodule

`default_nettype wire

// File: hw/rom_load_ctrl.sv
//////////////////////////////
// ROM load control
// console reset and clkref from the loading edges, loader
// write stretch onto the cpu memory port, mapper flags
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rom_load_ctrl (
    input  wire                                  clk,
    input  wire                                  sys_resetn,
    // loader
    input  wire                                  i_loading,
    input  wire                                  i_loader_write,
    input  wire [nes_board_pkg::NES_ADDR_W-1:0]  i_loader_addr,
    input  wire [7:0]                            i_loader_data,
    input  wire                                  i_loader_done,
    input  wire [nes_board_pkg::FLAGS_W-1:0]     i_loader_flags,
    // NES cpu
    input  wire [nes_board_pkg::NES_ADDR_W-1:0]  i_cpu_addr,
    input  wire [7:0]                            i_cpu_dout,
    input  wire                                  i_cpu_write,
    input  wire                                  i_cpu_read,
    // memory cpu port
    output logic [nes_board_pkg::NES_ADDR_W-1:0] o_cpu_mem_addr,
    output logic [7:0]                           o_cpu_mem_din,
    output logic                                 o_cpu_mem_we,
    output logic                                 o_cpu_mem_oe,
    // console
    output logic                                 o_reset_nes,
    output logic                                 o_clkref,
    output logic [nes_board_pkg::FLAGS_W-1:0]    o_mapper_flags,
    output logic                                 o_ext_audio
);

    logic                                 loading_r;
    logic                                 loading_rr;
    logic                                 ld_write_r;
    logic                                 ld_we;     // two-cycle loader write
    logic [nes_board_pkg::NES_ADDR_W-1:0] ld_addr;
    logic [7:0]                           ld_data;

    //////////////////////////////
    // load edges
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r   <= 1'b0;
            loading_rr  <= 1'b0;
            o_reset_nes <= 1'b1;
            o_clkref    <= 1'b0;
        end else begin
            loading_r  <= i_loading;
            loading_rr <= loading_r;
            o_clkref   <= ~o_clkref;
            if (!loading_r && loading_rr) begin
                o_reset_nes <= 1'b0;    // rom in place, let the console run
                o_clkref    <= 1'b1;    // realign sdram phase
            end else if (loading_r && !loading_rr) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

    // stretch each loader pulse to two cycles
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            ld_write_r <= 1'b0;
            ld_we      <= 1'b0;
        end else begin
            ld_write_r <= i_loader_write;
            ld_we      <= i_loader_write | ld_write_r;
        end
    end

    always_ff @(posedge clk) begin
        if (i_loader_write) begin
            ld_addr <= i_loader_addr;
            ld_data <= i_loader_data;
        end
        if (i_loader_done)
            o_mapper_flags <= i_loader_flags;
    end

    // loader owns the port while loading
    assign o_cpu_mem_addr = i_loading ? ld_addr : i_cpu_addr;
    assign o_cpu_mem_din  = i_loading ? ld_data : i_cpu_dout;
    assign o_cpu_mem_we   = ld_we | i_cpu_write;
    assign o_cpu_mem_oe   = ~i_loading & i_cpu_read;

    always_comb begin
        o_ext_audio = 1'b0;
        for (int i = 0; i < nes_board_pkg::EXT_AUDIO_N; i++) begin
            if (o_mapper_flags[nes_board_pkg::MAPPER_W-1:0] ==
                nes_board_pkg::EXT_AUDIO_MAPPERS[i*nes_board_pkg::MAPPER_W +: 8])
                o_ext_audio = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_mem_bridge.sv
//////////////////////////////
// softcore to memory bridge
// splits each 32-bit access into 16-bit requests on a
// toggle req/ack port; one-half writes take one request
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rv_mem_bridge (
    input  wire                                   clk,
    input  wire                                   sys_resetn,
    // softcore side
    input  wire                                   i_rv_valid,
    input  wire [nes_board_pkg::RV_ADDR_W-1:0]    i_rv_addr,
    input  wire [31:0]                            i_rv_wdata,
    input  wire [3:0]                             i_rv_wstrb,
    output logic                                  o_rv_ready,
    output logic [31:0]                           o_rv_rdata,
    // memory side
    output logic                                  o_mem_req,
    input  wire                                   i_mem_req_ack,
    output logic [nes_board_pkg::HALF_ADDR_W-1:0] o_mem_addr,
    output logic [15:0]                           o_mem_din,
    output logic [1:0]                            o_mem_ds,
    output logic                                  o_mem_we,
    input  wire [15:0]                            i_mem_dout
);

    nes_board_pkg::rv_state_e state;

    logic        valid_r;
    logic        pending;       // one access remembered while busy
    logic        word;          // 0 low half, 1 high half
    logic [15:0] rdata_lo;

    wire is_write = |i_rv_wstrb;
    wire new_req  = i_rv_valid & ~valid_r;
    wire mem_done = (o_mem_req == i_mem_req_ack);

    assign o_mem_addr = {i_rv_addr[20:2], word};
    assign o_mem_din  = word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    assign o_rv_rdata = {i_mem_dout, rdata_lo};    // high half still held by memory

    //////////////////////////////
    // request FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= nes_board_pkg::RV_IDLE;
            valid_r    <= 1'b0;
            pending    <= 1'b0;
            o_rv_ready <= 1'b0;
            o_mem_req  <= 1'b0;
            o_mem_we   <= 1'b0;
            o_mem_ds   <= 2'b00;
            word       <= 1'b0;
        end else begin
            valid_r    <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (new_req)
                pending <= 1'b1;

            case (state)
                nes_board_pkg::RV_IDLE: begin
                    if (pending || new_req) begin
                        pending   <= 1'b0;
                        o_mem_req <= ~o_mem_req;
                        o_mem_we  <= is_write;
                        if (is_write && i_rv_wstrb[1:0] == 2'b00) begin
                            // upper half only
                            word     <= 1'b1;
                            o_mem_ds <= i_rv_wstrb[3:2];
                            state    <= nes_board_pkg::RV_WAIT1;
                        end else begin
                            word     <= 1'b0;
                            o_mem_ds <= is_write ? i_rv_wstrb[1:0] : 2'b11;
                            state    <= nes_board_pkg::RV_WAIT0;
                        end
                    end
                end

                nes_board_pkg::RV_WAIT0: begin
                    if (mem_done) begin
                        if (!o_mem_we) begin
                            state <= nes_board_pkg::RV_DATA0;
                        end else if (i_rv_wstrb[3:2] == 2'b00) begin
                            o_rv_ready <= 1'b1;     // lower half only, done
                            state      <= nes_board_pkg::RV_IDLE;
                        end else begin
                            o_mem_req <= ~o_mem_req;
                            word      <= 1'b1;
                            o_mem_ds  <= i_rv_wstrb[3:2];
                            state     <= nes_board_pkg::RV_WAIT1;
                        end
                    end
                end

                // low half is latched below, then ask for the high half
                nes_board_pkg::RV_DATA0: begin
                    o_mem_req <= ~o_mem_req;
                    word      <= 1'b1;
                    o_mem_ds  <= 2'b11;
                    state     <= nes_board_pkg::RV_WAIT1;
                end

                nes_board_pkg::RV_WAIT1: begin
                    if (mem_done) begin
                        if (o_mem_we) begin
                            o_rv_ready <= 1'b1;
                            state      <= nes_board_pkg::RV_IDLE;
                        end else begin
                            state <= nes_board_pkg::RV_DATA1;
                        end
                    end
                end

                nes_board_pkg::RV_DATA1: begin
                    o_rv_ready <= 1'b1;
                    state      <= nes_board_pkg::RV_IDLE;
                end

                default: state <= nes_board_pkg::RV_IDLE;
            endcase
        end
    end

    // low read half
    always_ff @(posedge clk) begin
        if (state == nes_board_pkg::RV_DATA0)
            rdata_lo <= i_mem_dout;
    end

endmodule

`default_nettype wire

// File: test/nes_board_chk.sv
//////////////////////////////
// protocol assertions on the board top
// bound into the top level by the testbench
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module nes_board_chk (
    input wire clk,
    input wire sys_resetn,
    input wire i_rv_ready,
    input wire i_loading,
    input wire i_reset_nes,
    input wire i_cpu_mem_oe
);

    int n_fail = 0;     // failed assertions so far

    ready_pulse: assert property (@(posedge clk) disable iff (!sys_resetn)
        i_rv_ready |=> !i_rv_ready)
    else begin
        $error("softcore ready stayed high for a second cycle");
        n_fail++;
    end

    // console held in reset once loading is seen twice
    reset_in_load: assert property (@(posedge clk) disable iff (!sys_resetn)
        i_loading && $past(i_loading) |=> i_reset_nes)
    else begin
        $error("console reset low during loading");
        n_fail++;
    end

    no_oe_in_load: assert property (@(posedge clk) disable iff (!sys_resetn)
        i_loading |-> !i_cpu_mem_oe)
    else begin
        $error("cpu memory oe high during loading");
        n_fail++;
    end

endmodule

`default_nettype wire

// File: test/nes_board_tb.sv
//////////////////////////////
// directed testbench for the board glue
// toggle-port memory model and loader stimulus around
// the top level with one task per feature
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module nes_board_tb;

    logic                                  clk;
    logic                                  sys_resetn;
    logic                                  i_rv_valid;
    logic [nes_board_pkg::RV_ADDR_W-1:0]   i_rv_addr;
    logic [31:0]                           i_rv_wdata;
    logic [31:0]                           o_rv_rdata;
    logic [3:0]                            i_rv_wstrb;
    logic                                  o_rv_ready;
    logic                                  o_mem_req;
    logic                                  i_mem_req_ack;
    logic                                  o_mem_we;
    logic [nes_board_pkg::HALF_ADDR_W-1:0] o_mem_addr;
    logic [15:0]                           o_mem_din;
    logic [15:0]                           i_mem_dout;
    logic [1:0]                            o_mem_ds;
    logic                                  i_loading;
    logic                                  i_loader_write;
    logic                                  i_loader_done;
    logic [nes_board_pkg::NES_ADDR_W-1:0]  i_loader_addr;
    logic [7:0]                            i_loader_data;
    logic [nes_board_pkg::FLAGS_W-1:0]     i_loader_flags;
    logic [nes_board_pkg::NES_ADDR_W-1:0]  i_cpu_addr;
    logic [7:0]                            i_cpu_dout;
    logic                                  i_cpu_write;
    logic                                  i_cpu_read;
    logic [nes_board_pkg::NES_ADDR_W-1:0]  o_cpu_mem_addr;
    logic [7:0]                            o_cpu_mem_din;
    logic                                  o_cpu_mem_we;
    logic                                  o_cpu_mem_oe;
    logic                                  o_reset_nes;
    logic                                  o_clkref;
    logic [nes_board_pkg::FLAGS_W-1:0]     o_mapper_flags;
    logic                                  o_ext_audio;
    logic [nes_board_pkg::BTN_W-1:0]       i_joy1_btns;
    logic [nes_board_pkg::BTN_W-1:0]       i_joy2_btns;
    logic                                  i_joypad_strobe;
    logic [1:0]                            i_joypad_clock;
    logic                                  o_joypad1_data;
    logic                                  o_joypad2_data;

    logic [15:0] mem [logic [19:0]];    // written halves only
    logic [15:0] half_q;
    int          ack_delay [64];
    int          req_count  = 0;
    int          n_mismatch = 0;
    int          n_timeout  = 0;

    nes_board_top UUT (.*);

    bind nes_board_top nes_board_chk u_chk (
        .clk(clk), .sys_resetn(sys_resetn), .i_rv_ready(o_rv_ready),
        .i_loading(i_loading), .i_reset_nes(o_reset_nes), .i_cpu_mem_oe(o_cpu_mem_oe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // unwritten halves return a pattern of the whole address
    function automatic logic [15:0] read_half(input logic [19:0] a);
        if (mem.exists(a))
            return mem[a];
        return a[15:0] ^ {a[3:0], a[19:8]};
    endfunction

    task automatic report_mismatch(input string test, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
        n_mismatch++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        n_timeout++;
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////
    initial begin
        i_mem_req_ack = 1'b0;
        i_mem_dout    = 16'h0000;
        forever begin
            @(negedge clk);
            if (o_mem_req != i_mem_req_ack) begin
                repeat (ack_delay[req_count % 64]) @(negedge clk);
                half_q = read_half(o_mem_addr);
                if (o_mem_we) begin
                    if (o_mem_ds[0])
                        half_q[7:0] = o_mem_din[7:0];
                    if (o_mem_ds[1])
                        half_q[15:8] = o_mem_din[15:8];
                    mem[o_mem_addr] = half_q;
                end else begin
                    i_mem_dout = half_q;    // held until the next request
                end
                req_count++;
                i_mem_req_ack = o_mem_req;
            end
        end
    end

    // one softcore access with valid held until ready
    task automatic bus_access(input logic [22:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int t;
        @(negedge clk);
        i_rv_valid = 1'b1;
        i_rv_addr  = addr;
        i_rv_wdata = wdata;
        i_rv_wstrb = wstrb;
        t = 0;
        @(negedge clk);
        while (!o_rv_ready && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (!o_rv_ready)
            report_timeout("softcore ready");
        rdata      = o_rv_rdata;
        i_rv_valid = 1'b0;
    endtask

    task automatic run_bridge_reads();
        logic [22:0] a;
        logic [31:0] exp;
        logic [31:0] got;
        int          n0;
        for (int i = 0; i < 16; i++) begin
            a   = {2'b00, 19'($urandom), 2'b00};
            exp = {read_half({a[20:2], 1'b1}), read_half({a[20:2], 1'b0})};
            n0  = req_count;
            bus_access(a, 32'h0, 4'h0, got);
            if (got !== exp)
                report_mismatch("bridge read", exp, got);
            if (req_count - n0 != 2)
                report_mismatch("bridge read requests", 2, req_count - n0);
        end
    endtask

    task automatic run_bridge_writes();
        logic [3:0]  strb [7] = '{4'b0011, 4'b1100, 4'b1111, 4'b0001,
                                  4'b0100, 4'b1000, 4'b0010};
        logic [22:0] a;
        logic [31:0] old;
        logic [31:0] wd;
        logic [31:0] exp;
        logic [31:0] got;
        int          n0;
        int          nreq;
        for (int i = 0; i < 7; i++) begin
            a   = {2'b00, 19'($urandom), 2'b00};
            old = {read_half({a[20:2], 1'b1}), read_half({a[20:2], 1'b0})};
            wd  = $urandom;
            for (int b = 0; b < 4; b++)
                exp[8*b +: 8] = strb[i][b] ? wd[8*b +: 8] : old[8*b +: 8];
            nreq = (|strb[i][1:0] && |strb[i][3:2]) ? 2 : 1;
            n0   = req_count;
            bus_access(a, wd, strb[i], got);
            if (req_count - n0 != nreq)
                report_mismatch("bridge write requests", nreq, req_count - n0);
            bus_access(a, 32'h0, 4'h0, got);
            if (got !== exp)
                report_mismatch("bridge write readback", exp, got);
        end
    endtask

    //////////////////////////////
    // ROM load
    //////////////////////////////
    task automatic load_rom(input logic [7:0] mapper);
        logic [63:0] flags;
        logic [21:0] wa;
        logic [7:0]  wd;
        logic        ext;
        int          t;
        int          n_we;
        @(negedge clk);
        i_loading  = 1'b1;
        i_cpu_read = 1'b1;      // cpu read must stay masked
        t = 0;
        while (!o_reset_nes && t < 8) begin
            @(negedge clk);
            t++;
        end
        if (!o_reset_nes)
            report_timeout("console reset rise");
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            wa = 22'($urandom);
            wd = 8'($urandom);
            i_loader_write = 1'b1;
            i_loader_addr  = wa;
            i_loader_data  = wd;
            @(negedge clk);
            i_loader_write = 1'b0;
            i_loader_addr  = ~wa;
            i_loader_data  = ~wd;
            n_we = 0;
            repeat (4) begin
                if (o_cpu_mem_we) begin
                    n_we++;
                    if (o_cpu_mem_addr !== wa)
                        report_mismatch("loader write addr", wa, o_cpu_mem_addr);
                    if (o_cpu_mem_din !== wd)
                        report_mismatch("loader write data", wd, o_cpu_mem_din);
                end
                if (o_cpu_mem_oe !== 1'b0)
                    report_mismatch("oe while loading", 0, o_cpu_mem_oe);
                @(negedge clk);
            end
            if (n_we != 2)
                report_mismatch("loader we cycles", 2, n_we);
        end
        flags          = {$urandom, 24'($urandom), mapper};
        i_loader_flags = flags;
        i_loader_done  = 1'b1;
        @(negedge clk);
        i_loader_done  = 1'b0;
        i_loader_flags = ~flags;
        @(negedge clk);
        if (o_mapper_flags !== flags)
            report_mismatch("mapper flags", flags, o_mapper_flags);
        ext = (mapper == 8'd19 || mapper == 8'd24 || mapper == 8'd26);
        if (o_ext_audio !== ext)
            report_mismatch("ext audio", ext, o_ext_audio);
        i_loading = 1'b0;
        t = 0;
        while (o_reset_nes && t < 8) begin
            @(negedge clk);
            t++;
        end
        if (o_reset_nes)
            report_timeout("console reset fall");
        else if (o_clkref !== 1'b1)
            report_mismatch("clkref at load end", 1, o_clkref);
        // cpu owns the port again
        i_cpu_addr  = 22'($urandom);
        i_cpu_dout  = 8'($urandom);
        i_cpu_write = 1'b1;
        @(negedge clk);
        if (o_clkref !== 1'b0)
            report_mismatch("clkref toggle", 0, o_clkref);
        if (o_cpu_mem_addr !== i_cpu_addr)
            report_mismatch("cpu addr pass", i_cpu_addr, o_cpu_mem_addr);
        if (o_cpu_mem_din !== i_cpu_dout)
            report_mismatch("cpu data pass", i_cpu_dout, o_cpu_mem_din);
        if ({o_cpu_mem_we, o_cpu_mem_oe} !== 2'b11)
            report_mismatch("cpu we oe pass", 2'b11, {o_cpu_mem_we, o_cpu_mem_oe});
        i_cpu_write = 1'b0;
        i_cpu_read  = 1'b0;
    endtask

    //////////////////////////////
    // joypads
    //////////////////////////////
    task automatic run_joypad_serial();
        logic [11:0] b1;
        logic [11:0] b2;
        logic [1:0]  exp;
        b1 = {4'h0, 8'($urandom)};
        b2 = {4'h0, 8'($urandom)};
        @(negedge clk);
        i_joy1_btns     = b1;
        i_joy2_btns     = b2;
        i_joypad_strobe = 1'b1;
        @(negedge clk);
        i_joypad_strobe = 1'b0;
        for (int i = 0; i < 11; i++) begin
            @(negedge clk);
            exp = (i < 8) ? {b2[i], b1[i]} : 2'b11;   // ones after the last button
            if ({o_joypad2_data, o_joypad1_data} !== exp)
                report_mismatch("joypad serial", exp, {o_joypad2_data, o_joypad1_data});
            i_joypad_clock = 2'b11;
            repeat (2) @(negedge clk);
            i_joypad_clock = 2'b00;
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic run_autofire();
        logic seen_hi;
        logic seen_lo;
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        @(negedge clk);
        i_joy1_btns = 12'h100;      // autofire A held with A itself released
        i_joy2_btns = 12'h000;
        repeat (4 * nes_board_pkg::AUTOFIRE_HALF_PERIOD) begin
            @(negedge clk);
            i_joypad_strobe = 1'b1;
            @(negedge clk);
            i_joypad_strobe = 1'b0;
            if (o_joypad1_data)
                seen_hi = 1'b1;
            else
                seen_lo = 1'b1;
        end
        if (!seen_hi || !seen_lo)
            report_mismatch("autofire toggle", 2'b11, {seen_hi, seen_lo});
        i_joy1_btns = 12'h000;
        repeat (8) begin
            @(negedge clk);
            i_joypad_strobe = 1'b1;
            @(negedge clk);
            i_joypad_strobe = 1'b0;
            if (o_joypad1_data !== 1'b0)
                report_mismatch("autofire release", 0, o_joypad1_data);
        end
    endtask

    initial begin
        void'($urandom(32'hdc88_ec1a));
        for (int i = 0; i < 64; i++)
            ack_delay[i] = $urandom_range(5, 0);
        sys_resetn      = 1'b0;
        i_rv_valid      = 1'b0;
        i_rv_addr       = '0;
        i_rv_wdata      = '0;
        i_rv_wstrb      = '0;
        i_loading       = 1'b0;
        i_loader_write  = 1'b0;
        i_loader_addr   = '0;
        i_loader_data   = '0;
        i_loader_done   = 1'b0;
        i_loader_flags  = '0;
        i_cpu_addr      = '0;
        i_cpu_dout      = '0;
        i_cpu_write     = 1'b0;
        i_cpu_read      = 1'b0;
        i_joy1_btns     = '0;
        i_joy2_btns     = '0;
        i_joypad_strobe = 1'b0;
        i_joypad_clock  = 2'b00;
        repeat (4) @(negedge clk);
        sys_resetn = 1'b1;
        run_bridge_reads();
        run_bridge_writes();
        load_rom(8'd19);
        load_rom(8'd4);
        load_rom(8'd24);
        load_rom(8'd25);
        load_rom(8'd26);
        run_joypad_serial();
        run_autofire();
        @(negedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 n_mismatch, n_timeout, UUT.u_chk.n_fail);
        if (n_mismatch + n_timeout + UUT.u_chk.n_fail == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
